//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= st_mem_tb
RTL_TOP    ?= st_mem_top
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/st_mem_pkg.sv
package st_mem_pkg;

	// bus widths
	localparam int ADDR_W = 23;  // word address, byte address bits 23..1
	localparam int DATA_W = 16;

	// mmu bus_cycle phases
	localparam logic [1:0] SLOT_PRE   = 2'd0;  // precycle, upload strobe sampled here
	localparam logic [1:0] SLOT_CPU   = 2'd1;  // cpu, blitter or upload
	localparam logic [1:0] SLOT_VIDEO = 2'd2;  // viking fetch, also the shifter slot

	// top six address bits of the viking frame buffer
	localparam logic [5:0] REGION_VIKING_LO = 6'b110000;  // $c0xxxx
	localparam logic [5:0] REGION_VIKING_HI = 6'b111010;  // $e80000 in steroids mode

	// upload address marks deciding the tos image size
	localparam logic [5:0] TOS192_MARK = 6'b111111;  // $fc0000 and up, 192k image
	localparam logic [3:0] TOS256_NIB  = 4'he;       // $exxxxx, 256k image

	// where the rom2 window lands in sdram
	localparam logic [3:0] ROM_REGION_256 = 4'he;
	localparam logic [3:0] ROM_REGION_192 = 4'hf;
	localparam logic [1:0] ROM_BANK_256   = 2'b00;
	localparam logic [1:0] ROM_BANK_192   = 2'b11;

	// one rom word address, seen either flat or split into its fields
	typedef union packed {
		logic [ADDR_W-1:0] lin;  // plain word address
		struct packed {
			logic [3:0]  region;  // byte bits 23..20
			logic [1:0]  bank;    // byte bits 19..18
			logic [16:0] offset;  // byte bits 17..1
		} rom;
	} rom_addr_u;

endpackage

//--- dv/st_mem_tests.svh
// directed tests for st_mem_top, every step drives on the falling edge

// rom2 window must show the given region and bank with cpu offset 17..1
task automatic check_rom_window(input logic [3:0] region, input logic [1:0] bank);
	rom_addr_u exp;
	exp.rom.region = region;
	exp.rom.bank   = bank;
	exp.rom.offset = cpu_a[17:1];
	check_addr("rom_addr_o", rom_addr.lin, exp.lin);
endtask

task automatic test_reset();
	logic [31:0] r;
	begin_test("reset");
	get_rand(r);
	@(negedge clk_32);
	cpu_a = r[22:0];
	#SAMPLE_DLY;
	check_bit("sdram_we_o", sdram_we, 1'b0);
	check_bit("sdram_oe_o", sdram_oe, 1'b0);
	check_bit("viking_active_o", viking_active, 1'b0);
	check_addr("rom_addr_o", rom_addr.lin, r[22:0]);  // window closed, passthrough
	@(negedge clk_32);
	rom2_n = 1'b0;
	#SAMPLE_DLY;
	check_rom_window(4'he, 2'b00);  // flag clear, 256k layout
	@(negedge clk_32);
	rom2_n = 1'b1;
	end_test();
endtask

// one ras drop after a precharge cycle, strobe lasts exactly one cycle
task automatic mmu_access(input logic we_n, input logic [ADDR_W:1] addr);
	logic [31:0] r;
	logic exp_oe;
	get_rand(r);
	@(negedge clk_32);
	ras_n = 1'b1;
	@(negedge clk_32);
	mmu_we_n = we_n;
	mmu_a = addr;
	mmu_uds = r[0];
	mmu_lds = r[1];
	mmu_din = r[31:16];
	ras_n = 1'b0;
	#SAMPLE_DLY;
	exp_oe = we_n & (addr != '0);  // address 0 never reads
	check_bit("sdram_oe_o", sdram_oe, exp_oe);
	check_bit("sdram_we_o", sdram_we, ~we_n);
	check_addr("sdram_addr_o", sdram_addr, addr);
	check_bit("sdram_uds_o", sdram_uds, r[0]);
	check_bit("sdram_lds_o", sdram_lds, r[1]);
	check_data("sdram_din_o", sdram_din, r[31:16]);
	@(negedge clk_32);  // ras still low
	#SAMPLE_DLY;
	check_bit("sdram_oe_o", sdram_oe, 1'b0);
	check_bit("sdram_we_o", sdram_we, 1'b0);
endtask

task automatic test_mmu_path();
	logic [31:0] r;
	logic [ADDR_W:1] a;
	begin_test("mmu_path");
	@(negedge clk_32);
	bus_cycle = SLOT_PRE;
	repeat (3) begin
		get_rand(r);
		a = r[22:0];
		if (a == '0) a[1] = 1'b1;
		mmu_access(1'b1, a);      // read
		mmu_access(1'b0, r[31:9]);  // write
	end
	mmu_access(1'b1, '0);
	@(negedge clk_32);
	ras_n = 1'b1;
	end_test();
endtask

// precycle sample, then the cpu slot where a toggle lands as one write
task automatic upload_word(input logic toggle, input logic en, input logic exp_we);
	logic [31:0] r;
	get_rand(r);
	@(negedge clk_32);
	bus_cycle = SLOT_PRE;
	mhz8_en1 = en;
	dio_strobe = dio_strobe ^ toggle;
	@(negedge clk_32);
	bus_cycle = SLOT_CPU;
	mhz8_en1 = 1'b0;
	dio_addr = r[22:0];
	dio_data = r[31:16];
	#SAMPLE_DLY;
	check_bit("sdram_we_o", sdram_we, exp_we);
	check_bit("sdram_oe_o", sdram_oe, 1'b0);
	check_addr("sdram_addr_o", sdram_addr, r[22:0]);
	check_data("sdram_din_o", sdram_din, r[31:16]);
	check_bit("sdram_uds_o", sdram_uds, 1'b1);
	check_bit("sdram_lds_o", sdram_lds, 1'b1);
	@(negedge clk_32);  // same slot, pulse already over
	#SAMPLE_DLY;
	check_bit("sdram_we_o", sdram_we, 1'b0);
endtask

task automatic test_upload();
	begin_test("upload");
	@(negedge clk_32);
	dio_download = 1'b1;
	mmu_uds = 1'b0;  // mmu lanes off so both lanes must come from the slot owner
	mmu_lds = 1'b0;
	repeat (3) upload_word(1'b1, 1'b1, 1'b1);
	upload_word(1'b0, 1'b1, 1'b0);  // strobe unchanged
	upload_word(1'b1, 1'b0, 1'b0);  // toggle while not enabled, not sampled
	upload_word(1'b0, 1'b1, 1'b1);  // picked up at the next enabled precycle
	@(negedge clk_32);
	dio_download = 1'b0;
	bus_cycle = SLOT_PRE;
	end_test();
endtask

task automatic test_rom_remap();
	logic [31:0] r;
	begin_test("rom_remap");
	get_rand(r);
	@(negedge clk_32);
	dio_download = 1'b1;
	dio_addr = {6'b111111, r[16:0]};  // 192k image
	@(negedge clk_32);
	dio_download = 1'b0;
	rom2_n = 1'b0;
	cpu_a = r[31:9];
	#SAMPLE_DLY;
	check_rom_window(4'hf, 2'b11);
	@(negedge clk_32);
	dio_download = 1'b1;
	dio_addr = {4'he, r[18:0]};  // 256k image
	@(negedge clk_32);
	dio_download = 1'b0;
	#SAMPLE_DLY;
	check_rom_window(4'he, 2'b00);
	@(negedge clk_32);
	rom2_n = 1'b1;
	#SAMPLE_DLY;
	check_addr("rom_addr_o", rom_addr.lin, r[31:9]);
	end_test();
endtask

task automatic test_blitter();
	logic [31:0] r;
	logic [31:0] d;
	begin_test("blitter");
	repeat (3) begin
		get_rand(r);
		get_rand(d);
		@(negedge clk_32);
		bus_cycle = SLOT_CPU;
		blit_bgack = 1'b1;
		blit_addr = r[22:0];
		blit_read = r[23];
		blit_write = ~r[23];
		blit_data = d[15:0];
		#SAMPLE_DLY;
		check_addr("sdram_addr_o", sdram_addr, r[22:0]);
		check_bit("sdram_oe_o", sdram_oe, r[23]);
		check_bit("sdram_we_o", sdram_we, ~r[23]);
		check_bit("sdram_uds_o", sdram_uds, 1'b1);
		check_bit("sdram_lds_o", sdram_lds, 1'b1);
		check_data("sdram_din_o", sdram_din, d[15:0]);
	end
	@(negedge clk_32);
	bus_cycle = SLOT_PRE;  // mmu address back, data still blitter
	mmu_a = d[31:9];
	#SAMPLE_DLY;
	check_addr("sdram_addr_o", sdram_addr, d[31:9]);
	check_data("sdram_din_o", sdram_din, d[15:0]);
	@(negedge clk_32);
	blit_bgack = 1'b0;
	end_test();
endtask

// n cpu strobes at random addresses with the given top six bits
task automatic cpu_hits(input logic [5:0] top, input int n);
	logic [31:0] r;
	@(negedge clk_32);
	repeat (n) begin
		get_rand(r);
		cpu_a = {top, r[16:0]};
		as_n = 1'b0;
		@(negedge clk_32);
	end
	as_n = 1'b1;
	repeat (2) @(negedge clk_32);
	#SAMPLE_DLY;
endtask

task automatic wait_viking_active(input int max_cycles);
	int n;
	n = 0;
	while (viking_active !== 1'b1 && n < max_cycles) begin
		@(negedge clk_32);
		#SAMPLE_DLY;
		n++;
	end
	if (viking_active !== 1'b1) begin
		report_error($sformatf("viking_active did not rise within %0d cycles", max_cycles));
	end
endtask

task automatic test_viking();
	logic [31:0] r;
	begin_test("viking");
	get_rand(r);
	@(negedge clk_32);
	mhz8_en1 = 1'b1;
	viking_enable = 1'b1;
	bus_cycle = SLOT_VIDEO;
	viking_read = 1'b1;
	viking_addr = r[22:0];
	mmu_a = r[31:9];
	#SAMPLE_DLY;
	check_addr("sdram_addr_o", sdram_addr, r[31:9]);  // not active yet, mmu keeps it
	check_bit("sdram_oe_o", sdram_oe, 1'b0);
	cpu_hits(6'b110000, VIKING_HITS - 1);
	check_bit("viking_active_o", viking_active, 1'b0);
	cpu_hits(6'b110000, 1 + int'(r[3:0]));  // random overshoot
	wait_viking_active(4);
	repeat (3) begin
		get_rand(r);
		@(negedge clk_32);
		viking_addr = r[22:0];
		#SAMPLE_DLY;
		check_addr("sdram_addr_o", sdram_addr, r[22:0]);
		check_bit("sdram_oe_o", sdram_oe, 1'b1);
	end
	end_test();
endtask

task automatic test_viking_steroids();
	begin_test("viking_steroids");
	pulse_reset();
	@(negedge clk_32);
	steroids = 1'b1;
	#SAMPLE_DLY;
	check_bit("viking_active_o", viking_active, 1'b0);
	cpu_hits(6'b110000, VIKING_HITS + 8);  // low region ignored now
	check_bit("viking_active_o", viking_active, 1'b0);
	cpu_hits(6'b111010, VIKING_HITS);
	wait_viking_active(4);
	end_test();
endtask

//--- dv/st_mem_tb.sv
`timescale 1ns/1ns

module st_mem_tb;
	import st_mem_pkg::*;

	localparam int VIKING_HITS    = 255;
	localparam int SAMPLE_DLY     = 10;  // quarter period after the falling edge
	// viking tests take about 3x the hit count, all others stay well under 1000
	localparam int RUN_CYCLES     = 4 * VIKING_HITS + 980;
	localparam int TIMEOUT_CYCLES = 3 * RUN_CYCLES;

	logic clk_32;
	logic gen_rst_n;
	logic tb_rst_n;    // extra reset for tests that need a clean detector
	logic xsint;
	logic mhz8_en1;
	logic [1:0] bus_cycle;
	logic ras_n, mmu_we_n, mmu_uds, mmu_lds;
	logic dio_download, dio_strobe;
	logic blit_bgack, blit_read, blit_write;
	logic viking_read, rom2_n, as_n, viking_enable, steroids;
	logic [ADDR_W:1] mmu_a, dio_addr, blit_addr, viking_addr, cpu_a, sdram_addr;
	logic [DATA_W-1:0] mmu_din, dio_data, blit_data, sdram_din;
	logic sdram_oe, sdram_we, sdram_uds, sdram_lds, viking_active;
	rom_addr_u rom_addr;

	logic [31:0] rng_state = 32'h9ea2;
	int cycle_cnt = 0;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int test_fail_cnt = 0;
	int test_err_start = 0;
	string test_name;

	assign xsint = gen_rst_n & tb_rst_n;

	tb_clk_gen #(
		.PERIOD       (40),
		.RESET_CYCLES (10)
	) u_clk_gen (
		.clk_o   (clk_32),
		.rst_n_o (gen_rst_n)
	);

	st_mem_top #(
		.VIKING_HITS (VIKING_HITS)
	) dut0 (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en1_i      (mhz8_en1),
		.bus_cycle_i     (bus_cycle),
		.ras_n_i         (ras_n),
		.mmu_we_n_i      (mmu_we_n),
		.mmu_a_i         (mmu_a),
		.mmu_uds_i       (mmu_uds),
		.mmu_lds_i       (mmu_lds),
		.mmu_din_i       (mmu_din),
		.dio_download_i  (dio_download),
		.dio_addr_i      (dio_addr),
		.dio_data_i      (dio_data),
		.dio_strobe_i    (dio_strobe),
		.blit_bgack_i    (blit_bgack),
		.blit_addr_i     (blit_addr),
		.blit_read_i     (blit_read),
		.blit_write_i    (blit_write),
		.blit_data_i     (blit_data),
		.viking_addr_i   (viking_addr),
		.viking_read_i   (viking_read),
		.rom2_n_i        (rom2_n),
		.cpu_a_i         (cpu_a),
		.as_n_i          (as_n),
		.viking_enable_i (viking_enable),
		.steroids_i      (steroids),
		.sdram_addr_o    (sdram_addr),
		.sdram_oe_o      (sdram_oe),
		.sdram_we_o      (sdram_we),
		.sdram_uds_o     (sdram_uds),
		.sdram_lds_o     (sdram_lds),
		.sdram_din_o     (sdram_din),
		.rom_addr_o      (rom_addr),
		.viking_active_o (viking_active)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic get_rand(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	task automatic init_inputs();
		tb_rst_n = 1'b1;
		mhz8_en1 = 1'b0;
		bus_cycle = SLOT_PRE;
		ras_n = 1'b1;       // idle, no access
		mmu_we_n = 1'b1;
		mmu_uds = 1'b0;
		mmu_lds = 1'b0;
		mmu_a = '0;
		mmu_din = '0;
		dio_download = 1'b0;
		dio_strobe = 1'b0;
		dio_addr = '0;
		dio_data = '0;
		blit_bgack = 1'b0;
		blit_read = 1'b0;
		blit_write = 1'b0;
		blit_addr = '0;
		blit_data = '0;
		viking_read = 1'b0;
		viking_addr = '0;
		rom2_n = 1'b1;
		cpu_a = '0;
		as_n = 1'b1;
		viking_enable = 1'b0;
		steroids = 1'b0;
	endtask

	task automatic pulse_reset();
		@(negedge clk_32);
		tb_rst_n = 1'b0;
		dio_strobe = 1'b0;  // same level the sample register clears to
		repeat (2) @(negedge clk_32);
		tb_rst_n = 1'b1;
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W:1] got,
	                          input logic [ADDR_W:1] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_data(input string name, input logic [DATA_W-1:0] got,
	                          input logic [DATA_W-1:0] exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		err_cnt++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_err_start = err_cnt;
		test_cnt++;
	endtask

	task automatic end_test();
		int errs;
		errs = err_cnt - test_err_start;
		if (errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			test_fail_cnt++;
			$display("test %s: fail, %0d errors", test_name, errs);
		end
	endtask

	`include "st_mem_tests.svh"

	// hard stop in case a test hangs
	always @(posedge clk_32) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial begin
		init_inputs();
		wait (xsint === 1'b1);
		test_reset();
		test_mmu_path();
		test_upload();
		test_rom_remap();
		test_blitter();
		test_viking();
		test_viking_steroids();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
		         test_cnt, test_fail_cnt, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns

// free running clk_32 plus power-on reset for the testbench
module tb_clk_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);  // release away from the active edge
		rst_n_o = 1'b1;
	end

endmodule

//--- memory/ram_arbiter.sv
`timescale 1ns/1ns

// one sdram port shared by mmu, upload, blitter and viking
// slot comes from the mmu bus_cycle, no stalls, losers just wait
module ram_arbiter (
	input  logic                        clk_32,
	input  logic                        xsint,
	input  logic [1:0]                  bus_cycle_i,

	// mmu side
	input  logic                        ras_n_i,
	input  logic                        mmu_we_n_i,
	input  logic [st_mem_pkg::ADDR_W:1] mmu_a_i,
	input  logic                        mmu_uds_i,
	input  logic                        mmu_lds_i,
	input  logic [st_mem_pkg::DATA_W-1:0] mmu_din_i,

	// io controller upload
	input  logic                        dio_download_i,
	input  logic [st_mem_pkg::ADDR_W:1] dio_addr_i,
	input  logic [st_mem_pkg::DATA_W-1:0] dio_data_i,
	input  logic                        upload_we_i,

	// blitter bus master
	input  logic                        blit_bgack_i,
	input  logic [st_mem_pkg::ADDR_W:1] blit_addr_i,
	input  logic                        blit_read_i,
	input  logic                        blit_write_i,
	input  logic [st_mem_pkg::DATA_W-1:0] blit_data_i,

	// viking fetcher
	input  logic                        viking_active_i,
	input  logic [st_mem_pkg::ADDR_W:1] viking_addr_i,
	input  logic                        viking_read_i,

	// sdram controller
	output logic [st_mem_pkg::ADDR_W:1] sdram_addr_o,
	output logic                        sdram_oe_o,
	output logic                        sdram_we_o,
	output logic                        sdram_uds_o,
	output logic                        sdram_lds_o,
	output logic [st_mem_pkg::DATA_W-1:0] sdram_din_o
);
	import st_mem_pkg::*;

	logic ras_n_d;     // ras one clock back
	logic ras_fall;
	logic mmu_oe;
	logic mmu_we;
	logic cpu_slot;
	logic video_slot;
	logic viking_go;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_n_d <= 1'b1;  // idle high, no fake edge out of reset
		end else begin
			ras_n_d <= ras_n_i;
		end
	end

	// mmu access strobes last one clock, right where ras drops
	assign ras_fall = ras_n_d & ~ras_n_i;
	assign mmu_oe   = ras_fall & mmu_we_n_i & (|mmu_a_i);  // address 0 is no real read
	assign mmu_we   = ras_fall & ~mmu_we_n_i;

	assign cpu_slot   = (bus_cycle_i == SLOT_CPU);
	assign video_slot = (bus_cycle_i == SLOT_VIDEO);
	assign viking_go  = video_slot & viking_active_i & viking_read_i;  // driver loaded and fetching

	// address and strobes, fixed priority inside each slot
	always_comb begin
		sdram_addr_o = mmu_a_i;  // mmu unless someone else owns the slot
		sdram_oe_o   = mmu_oe;
		sdram_we_o   = mmu_we;
		sdram_uds_o  = mmu_uds_i;
		sdram_lds_o  = mmu_lds_i;
		if (cpu_slot && dio_download_i) begin
			// upload never reads, one pulse per strobe toggle
			sdram_addr_o = dio_addr_i;
			sdram_oe_o   = 1'b0;
			sdram_we_o   = upload_we_i;
			sdram_uds_o  = 1'b1;
			sdram_lds_o  = 1'b1;
		end else if (cpu_slot && blit_bgack_i) begin
			sdram_addr_o = blit_addr_i;  // blitter skips the mmu
			sdram_oe_o   = blit_read_i;
			sdram_we_o   = blit_write_i;
			sdram_uds_o  = 1'b1;         // always full words
			sdram_lds_o  = 1'b1;
		end else if (viking_go) begin
			sdram_addr_o = viking_addr_i;
			sdram_oe_o   = 1'b1;
		end
	end

	// write data does not care about the slot
	always_comb begin
		if (dio_download_i) begin
			sdram_din_o = dio_data_i;
		end else if (blit_bgack_i) begin
			sdram_din_o = blit_data_i;
		end else begin
			sdram_din_o = mmu_din_i;  // from the shifter data latch
		end
	end

endmodule

//--- memory/tos_rom_map.sv
`timescale 1ns/1ns

// 192k tos lives at $fc0000, 256k tos at $e00000
// the upload address tells which one came in, rom2 window follows it
module tos_rom_map (
	input  logic                        clk_32,
	input  logic                        xsint,
	input  logic                        dio_download_i,
	input  logic [st_mem_pkg::ADDR_W:1] dio_addr_i,
	input  logic                        rom2_n_i,   // rom window select, low active
	input  logic [st_mem_pkg::ADDR_W:1] cpu_a_i,
	output st_mem_pkg::rom_addr_u       rom_addr_o
);
	import st_mem_pkg::*;

	logic tos192k;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;  // assume 256k until told otherwise
		end else if (dio_download_i) begin
			if (dio_addr_i[ADDR_W -: 6] == TOS192_MARK) begin
				tos192k <= 1'b1;
			end else if (dio_addr_i[ADDR_W -: 4] == TOS256_NIB) begin
				tos192k <= 1'b0;
			end
			// other upload ranges (cartridge) leave the flag alone
		end
	end

	always_comb begin
		rom_addr_o.lin = cpu_a_i;  // outside the window, untouched
		if (!rom2_n_i) begin
			rom_addr_o.rom.offset = cpu_a_i[17:1];  // 128k words per bank
			if (tos192k) begin
				rom_addr_o.rom.region = ROM_REGION_192;
				rom_addr_o.rom.bank   = ROM_BANK_192;
			end else begin
				rom_addr_o.rom.region = ROM_REGION_256;
				rom_addr_o.rom.bank   = ROM_BANK_256;
			end
		end
	end

endmodule

//--- memory/upload_writer.sv
`timescale 1ns/1ns

// io controller toggles its strobe once per data word
// each toggle becomes one write pulse, placed so it lands in the cpu slot
module upload_writer (
	input  logic       clk_32,
	input  logic       xsint,
	input  logic       mhz8_en1_i,
	input  logic [1:0] bus_cycle_i,
	input  logic       dio_strobe_i,  // level toggles per word
	output logic       upload_we_o
);
	import st_mem_pkg::*;

	logic strobe_d;    // level seen at the last precycle sample
	logic sample_now;

	// one clock per 8 MHz period inside the precycle
	assign sample_now = mhz8_en1_i & (bus_cycle_i == SLOT_PRE);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_d    <= 1'b0;
			upload_we_o <= 1'b0;
		end else begin
			upload_we_o <= 1'b0;  // pulse is a single clock
			if (sample_now) begin
				strobe_d <= dio_strobe_i;
				// any change since the last sample is a new word
				if (dio_strobe_i ^ strobe_d) begin
					upload_we_o <= 1'b1;
				end
			end
		end
	end

endmodule

//--- sources.f
+incdir+dv
common/st_mem_pkg.sv
memory/ram_arbiter.sv
memory/upload_writer.sv
memory/tos_rom_map.sv
viking/viking_detect.sv
verilog/st_mem_top.sv
dv/tb_clk_gen.sv
dv/st_mem_tb.sv

//--- verilog/st_mem_top.sv
`timescale 1ns/1ns

// sdram sharing slice of the st top level
module st_mem_top #(
	parameter int VIKING_HITS = 255  // cpu hits before viking takes the video slot
) (
	input  logic                          clk_32,
	input  logic                          xsint,
	input  logic                          mhz8_en1_i,
	input  logic [1:0]                    bus_cycle_i,

	// mmu
	input  logic                          ras_n_i,
	input  logic                          mmu_we_n_i,
	input  logic [st_mem_pkg::ADDR_W:1]   mmu_a_i,
	input  logic                          mmu_uds_i,
	input  logic                          mmu_lds_i,
	input  logic [st_mem_pkg::DATA_W-1:0] mmu_din_i,

	// io controller upload
	input  logic                          dio_download_i,
	input  logic [st_mem_pkg::ADDR_W:1]   dio_addr_i,
	input  logic [st_mem_pkg::DATA_W-1:0] dio_data_i,
	input  logic                          dio_strobe_i,

	// blitter master port
	input  logic                          blit_bgack_i,
	input  logic [st_mem_pkg::ADDR_W:1]   blit_addr_i,
	input  logic                          blit_read_i,
	input  logic                          blit_write_i,
	input  logic [st_mem_pkg::DATA_W-1:0] blit_data_i,

	// viking fetcher
	input  logic [st_mem_pkg::ADDR_W:1]   viking_addr_i,
	input  logic                          viking_read_i,

	// cpu bus
	input  logic                          rom2_n_i,
	input  logic [st_mem_pkg::ADDR_W:1]   cpu_a_i,
	input  logic                          as_n_i,
	input  logic                          viking_enable_i,
	input  logic                          steroids_i,

	output logic [st_mem_pkg::ADDR_W:1]   sdram_addr_o,
	output logic                          sdram_oe_o,
	output logic                          sdram_we_o,
	output logic                          sdram_uds_o,
	output logic                          sdram_lds_o,
	output logic [st_mem_pkg::DATA_W-1:0] sdram_din_o,
	output st_mem_pkg::rom_addr_u         rom_addr_o,
	output logic                          viking_active_o
);

	logic upload_we;      // one clock per uploaded word
	logic viking_active;  // also selects the video output upstream

	assign viking_active_o = viking_active;

	upload_writer u_upload_writer (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.mhz8_en1_i   (mhz8_en1_i),
		.bus_cycle_i  (bus_cycle_i),
		.dio_strobe_i (dio_strobe_i),
		.upload_we_o  (upload_we)
	);

	tos_rom_map u_tos_rom_map (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.dio_download_i (dio_download_i),
		.dio_addr_i     (dio_addr_i),
		.rom2_n_i       (rom2_n_i),
		.cpu_a_i        (cpu_a_i),
		.rom_addr_o     (rom_addr_o)
	);

	viking_detect #(
		.VIKING_HITS (VIKING_HITS)
	) u_viking_detect (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en1_i      (mhz8_en1_i),
		.as_n_i          (as_n_i),
		.cpu_a_i         (cpu_a_i),
		.viking_enable_i (viking_enable_i),
		.steroids_i      (steroids_i),
		.viking_active_o (viking_active)
	);

	ram_arbiter u_ram_arbiter (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.bus_cycle_i     (bus_cycle_i),
		.ras_n_i         (ras_n_i),
		.mmu_we_n_i      (mmu_we_n_i),
		.mmu_a_i         (mmu_a_i),
		.mmu_uds_i       (mmu_uds_i),
		.mmu_lds_i       (mmu_lds_i),
		.mmu_din_i       (mmu_din_i),
		.dio_download_i  (dio_download_i),
		.dio_addr_i      (dio_addr_i),
		.dio_data_i      (dio_data_i),
		.upload_we_i     (upload_we),
		.blit_bgack_i    (blit_bgack_i),
		.blit_addr_i     (blit_addr_i),
		.blit_read_i     (blit_read_i),
		.blit_write_i    (blit_write_i),
		.blit_data_i     (blit_data_i),
		.viking_active_i (viking_active),
		.viking_addr_i   (viking_addr_i),
		.viking_read_i   (viking_read_i),
		.sdram_addr_o    (sdram_addr_o),
		.sdram_oe_o      (sdram_oe_o),
		.sdram_we_o      (sdram_we_o),
		.sdram_uds_o     (sdram_uds_o),
		.sdram_lds_o     (sdram_lds_o),
		.sdram_din_o     (sdram_din_o)
	);

endmodule

//--- viking/viking_detect.sv
`timescale 1ns/1ns

// a loaded viking driver hammers video memory, stray probes do not
// enough hits switch the video slot over to the viking fetcher
module viking_detect #(
	parameter int VIKING_HITS = 255
) (
	input  logic                        clk_32,
	input  logic                        xsint,
	input  logic                        mhz8_en1_i,
	input  logic                        as_n_i,
	input  logic [st_mem_pkg::ADDR_W:1] cpu_a_i,
	input  logic                        viking_enable_i,
	input  logic                        steroids_i,   // frame buffer moved to $e80000
	output logic                        viking_active_o
);
	import st_mem_pkg::*;

	localparam int CNT_W = $clog2(VIKING_HITS + 1);

	logic [CNT_W-1:0] hits;
	logic [5:0]       region;
	logic             hit;
	logic             full;

	assign region = steroids_i ? REGION_VIKING_HI : REGION_VIKING_LO;
	assign full   = (hits == CNT_W'(VIKING_HITS));  // saturated
	assign hit    = mhz8_en1_i & ~as_n_i & viking_enable_i &
	                (cpu_a_i[ADDR_W -: 6] == region);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			hits            <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (hit && !full) begin
				hits <= hits + CNT_W'(1);
			end
			if (full) begin
				viking_active_o <= 1'b1;  // sticky until reset
			end
		end
	end

endmodule
